// ==== sb_tx_pkg.sv ====
package sb_tx_pkg;

    localparam int SYM_BITS              = 10;    // Start + 8 data + stop
    localparam int SYM_CNT_W             = $clog2(SYM_BITS);
    localparam int RD_DATA_BYTES         = 3;
    localparam int DATA_IDX_W            = $clog2(RD_DATA_BYTES);
    localparam int DISCONNECT_MIN_CYCLES = 32;    // Quiet time before leaving disconnect
    localparam int QUIET_CNT_W           = $clog2(DISCONNECT_MIN_CYCLES);

    typedef logic [7:0]                   sym_byte_t;  // Symbol payload
    typedef logic [SYM_BITS-1:0]          sym_word_t;  // {stop, byte, start}
    typedef logic [15:0]                  crc_t;
    typedef logic [8*RD_DATA_BYTES-1:0]   rd_data_t;   // Byte 0 in [7:0], sent first
    typedef logic [2:0]                   txn_kind_t;

    // Transaction select codes, anything else is rejected
    localparam txn_kind_t KIND_RD_CMD = 3'd2;
    localparam txn_kind_t KIND_RD_RSP = 3'd3;
    localparam txn_kind_t KIND_LSE    = 3'd4;

    // Control symbols
    localparam sym_byte_t DLE_SYM     = 8'hFE;
    localparam sym_byte_t STX_CMD_SYM = 8'h05;
    localparam sym_byte_t STX_RSP_SYM = 8'h04;
    localparam sym_byte_t LSE_SYM     = 8'h80;
    localparam sym_byte_t CLSE_SYM    = 8'h7F;  // Complement of LSE
    localparam sym_byte_t ETX_SYM     = 8'h40;

    localparam sym_byte_t RD_ADDR     = 8'h4E;  // Register address of the read
    localparam sym_byte_t RD_LEN      = 8'h03;  // Length byte, three data bytes

    localparam crc_t CRC_POLY_REFL    = 16'hA001;  // 0x8005 bit-reversed

    // Sequencer states, one per symbol of a frame
    typedef enum logic [3:0] {
        DISCONNECT,  // Line held low
        IDLE,        // Line high, waiting for req
        DLE1,
        STX,
        ADDR,
        LEN,
        DATA,        // Read data bytes, response only
        CRC_LOW,
        CRC_HIGH,
        DLE2,
        ETX,
        LSE,
        CLSE,
        DONE         // ack high until req drops
    } frame_state_t;

    // Link status seen from outside
    typedef enum logic [1:0] {
        LINK_DISCONNECTED = 2'd0,
        LINK_IDLE         = 2'd1,
        LINK_BUSY         = 2'd2
    } link_state_t;

endpackage

// ==== sb_symbol_serializer.sv ====
`timescale 1ns/10ps

module sb_symbol_serializer (
    input  logic                 sb_clk,
    input  logic                 rst,
    input  logic                 sym_load,         // Capture sym_byte this cycle
    input  sb_tx_pkg::sym_byte_t sym_byte,
    input  logic                 line_idle_level,  // 1 connected, 0 disconnected
    output logic                 sbtx,
    output logic                 sym_done          // Last bit of symbol on line
);
    import sb_tx_pkg::*;

    sym_word_t            shift_q;   // Bit 0 is on the line
    logic [SYM_CNT_W-1:0] bit_cnt;   // Index of the bit on the line
    logic                 active;    // Symbol in flight
    logic                 last_bit;

    assign last_bit = (bit_cnt == SYM_CNT_W'(SYM_BITS - 1));

    // Bit counter and busy flag
    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (sym_load) begin       // Load wins over the stop bit
            active  <= 1'b1;
            bit_cnt <= '0;
        end else if (active) begin
            if (last_bit) begin
                active  <= 1'b0;           // Back to idle level
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Payload shifter, LSB first
    always_ff @(posedge sb_clk) begin
        if (sym_load) begin
            shift_q <= {1'b1, sym_byte, 1'b0};     // Stop, data, start
        end else if (active) begin
            shift_q <= {1'b1, shift_q[SYM_BITS-1:1]};  // Fill with idle ones
        end
    end

    // Line mux
    always_comb begin
        if (active) begin
            sbtx = shift_q[0];
        end else begin
            sbtx = line_idle_level;        // High idle or low disconnect
        end
    end

    assign sym_done = active && last_bit;  // Next load may come this cycle

endmodule

// ==== sb_crc16.sv ====
`timescale 1ns/10ps

module sb_crc16 (
    input  logic                 sb_clk,
    input  logic                 rst,
    input  logic                 crc_clear,  // Start of a new frame
    input  logic                 crc_feed,   // Fold sym_byte in
    input  sb_tx_pkg::sym_byte_t sym_byte,
    output sb_tx_pkg::crc_t      crc
);
    import sb_tx_pkg::*;

    crc_t crc_q;
    crc_t crc_nxt;

    // Eight reflected steps, LSB of the byte first
    function automatic crc_t crc_fold(crc_t crc_in, sym_byte_t b);
        crc_t c;
        c = crc_in ^ {8'h00, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_nxt = crc_fold(crc_q, sym_byte);

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            crc_q <= '0;
        end else if (crc_clear) begin
            crc_q <= '0;                   // Zero seed, no final xor
        end else if (crc_feed) begin
            crc_q <= crc_nxt;              // Visible next cycle
        end
    end

    assign crc = crc_q;

endmodule

// ==== sb_txn_sequencer.sv ====
`timescale 1ns/10ps

module sb_txn_sequencer (
    input  logic                    sb_clk,
    input  logic                    rst,
    input  logic                    req,              // Four-phase request
    input  sb_tx_pkg::txn_kind_t    trans_sel,
    input  sb_tx_pkg::rd_data_t     rd_data,          // Stable while req high
    input  logic                    disconnect_sbtx,
    input  logic                    sym_done,         // From serializer
    input  sb_tx_pkg::crc_t         crc,
    output logic                    ack,
    output logic                    sym_load,
    output sb_tx_pkg::sym_byte_t    sym_byte,
    output logic                    crc_clear,
    output logic                    crc_feed,
    output logic                    line_idle_level,
    output sb_tx_pkg::link_state_t  link_state,
    output logic                    disconnected
);
    import sb_tx_pkg::*;

    frame_state_t           state;
    frame_state_t           nxt;
    frame_state_t           sel_state;   // State whose byte is being loaded
    txn_kind_t              kind_q;      // Latched on acceptance
    logic                   start_q;     // First symbol of frame pending
    logic [DATA_IDX_W-1:0]  data_cnt;    // Data byte on the line
    logic [DATA_IDX_W-1:0]  sel_idx;     // Data byte being loaded
    logic [QUIET_CNT_W-1:0] quiet_cnt;   // Consecutive quiet cycles
    logic                   valid_kind;
    logic                   nxt_is_sym;
    logic                   quiet_done;
    logic                   last_data;

    assign valid_kind = (trans_sel == KIND_RD_CMD) || (trans_sel == KIND_RD_RSP) ||
                        (trans_sel == KIND_LSE);
    assign quiet_done = !disconnect_sbtx &&
                        (quiet_cnt == QUIET_CNT_W'(DISCONNECT_MIN_CYCLES - 1));
    assign last_data  = (data_cnt == DATA_IDX_W'(RD_DATA_BYTES - 1));

    // Next state, symbol states advance on the stop bit
    always_comb begin
        nxt = state;
        case (state)
            DISCONNECT: begin
                if (quiet_done) begin
                    nxt = IDLE;
                end
            end
            IDLE: begin
                if (disconnect_sbtx) begin
                    nxt = DISCONNECT;              // Only honoured between frames
                end else if (req) begin
                    nxt = valid_kind ? DLE1 : DONE;  // Bad kind acked at once
                end
            end
            DLE1: begin
                if (sym_done) begin
                    nxt = (kind_q == KIND_LSE) ? LSE : STX;
                end
            end
            STX: begin
                if (sym_done) begin
                    nxt = ADDR;
                end
            end
            ADDR: begin
                if (sym_done) begin
                    nxt = LEN;
                end
            end
            LEN: begin
                if (sym_done) begin
                    nxt = (kind_q == KIND_RD_RSP) ? DATA : CRC_LOW;
                end
            end
            DATA: begin
                if (sym_done && last_data) begin
                    nxt = CRC_LOW;
                end
            end
            CRC_LOW: begin
                if (sym_done) begin
                    nxt = CRC_HIGH;
                end
            end
            CRC_HIGH: begin
                if (sym_done) begin
                    nxt = DLE2;
                end
            end
            DLE2: begin
                if (sym_done) begin
                    nxt = ETX;
                end
            end
            ETX: begin
                if (sym_done) begin
                    nxt = DONE;
                end
            end
            LSE: begin
                if (sym_done) begin
                    nxt = CLSE;
                end
            end
            CLSE: begin
                if (sym_done) begin
                    nxt = DONE;
                end
            end
            DONE: begin
                if (!req) begin
                    nxt = IDLE;                    // Handshake closed
                end
            end
            default: nxt = DISCONNECT;
        endcase
    end

    assign nxt_is_sym = !(nxt inside {DISCONNECT, IDLE, DONE});

    // First DLE one cycle after acceptance, then chained on sym_done
    assign sym_load  = start_q || (sym_done && nxt_is_sym);
    assign sel_state = start_q ? state : nxt;
    assign sel_idx   = (state == DATA) ? data_cnt + 1'b1 : '0;

    // Byte for the symbol being loaded
    always_comb begin
        case (sel_state)
            DLE1, DLE2: sym_byte = DLE_SYM;
            STX:        sym_byte = (kind_q == KIND_RD_RSP) ? STX_RSP_SYM : STX_CMD_SYM;
            ADDR:       sym_byte = RD_ADDR;
            LEN:        sym_byte = RD_LEN;
            DATA:       sym_byte = rd_data[8*sel_idx +: 8];   // Byte 0 first
            CRC_LOW:    sym_byte = crc[7:0];
            CRC_HIGH:   sym_byte = crc[15:8];
            ETX:        sym_byte = ETX_SYM;
            LSE:        sym_byte = LSE_SYM;
            CLSE:       sym_byte = CLSE_SYM;
            default:    sym_byte = 8'hFF;                     // Not loaded
        endcase
    end

    // CRC spans STX through the last data byte
    assign crc_clear = sym_load && (sel_state == DLE1);
    assign crc_feed  = sym_load && (sel_state inside {STX, ADDR, LEN, DATA});

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            state     <= DISCONNECT;               // Line low out of reset
            start_q   <= 1'b0;
            kind_q    <= '0;
            data_cnt  <= '0;
            quiet_cnt <= '0;
        end else begin
            state   <= nxt;
            start_q <= (state == IDLE) && (nxt == DLE1);
            if ((state == IDLE) && req) begin
                kind_q <= trans_sel;               // Held for the whole frame
            end
            if (state != DATA) begin
                data_cnt <= '0;
            end else if (sym_done && (nxt == DATA)) begin
                data_cnt <= data_cnt + 1'b1;
            end
            if ((state == DISCONNECT) && !disconnect_sbtx) begin
                quiet_cnt <= quiet_cnt + 1'b1;
            end else begin
                quiet_cnt <= '0;                   // Restart on any disconnect
            end
        end
    end

    // Status decode
    assign ack             = (state == DONE);
    assign line_idle_level = (state != DISCONNECT);
    assign disconnected    = (state == DISCONNECT);

    always_comb begin
        case (state)
            DISCONNECT: link_state = LINK_DISCONNECTED;
            IDLE:       link_state = LINK_IDLE;
            default:    link_state = LINK_BUSY;      // Frame or ack pending
        endcase
    end

endmodule

// ==== sb_tx_top.sv ====
`timescale 1ns/10ps

module sb_tx_top (
    input  logic                    sb_clk,
    input  logic                    rst,              // Async, active low
    input  logic                    req,
    input  sb_tx_pkg::txn_kind_t    trans_sel,
    input  sb_tx_pkg::rd_data_t     rd_data,
    input  logic                    disconnect_sbtx,
    output logic                    ack,
    output logic                    sbtx,             // Serial sideband line
    output sb_tx_pkg::link_state_t  link_state,
    output logic                    disconnected
);
    import sb_tx_pkg::*;

    logic      sym_load;
    sym_byte_t sym_byte;   // Shared by CRC and serializer
    logic      sym_done;
    logic      crc_clear;
    logic      crc_feed;
    crc_t      crc;
    logic      line_idle_level;

    // Frame FSM and handshake
    sb_txn_sequencer u_seq (
        .sb_clk          (sb_clk),
        .rst             (rst),
        .req             (req),
        .trans_sel       (trans_sel),
        .rd_data         (rd_data),
        .disconnect_sbtx (disconnect_sbtx),
        .sym_done        (sym_done),
        .crc             (crc),
        .ack             (ack),
        .sym_load        (sym_load),
        .sym_byte        (sym_byte),
        .crc_clear       (crc_clear),
        .crc_feed        (crc_feed),
        .line_idle_level (line_idle_level),
        .link_state      (link_state),
        .disconnected    (disconnected)
    );

    // Frame check over body bytes
    sb_crc16 u_crc (
        .sb_clk    (sb_clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_feed  (crc_feed),
        .sym_byte  (sym_byte),
        .crc       (crc)
    );

    // Ten cycles per symbol
    sb_symbol_serializer u_ser (
        .sb_clk          (sb_clk),
        .rst             (rst),
        .sym_load        (sym_load),
        .sym_byte        (sym_byte),
        .line_idle_level (line_idle_level),
        .sbtx            (sbtx),
        .sym_done        (sym_done)
    );

endmodule

// ==== sb_tx_tb_model.svh ====
`ifndef SB_TX_TB_MODEL_SVH
`define SB_TX_TB_MODEL_SVH

typedef sb_tx_pkg::sym_byte_t model_byte_q_t[$];    // Expected bytes of one frame

localparam int MODEL_MAX_FRAME_SYMS = 11;            // Read response is the longest

// One byte through the reflected CRC-16, bit by bit, LSB first
function automatic sb_tx_pkg::crc_t model_crc_byte(sb_tx_pkg::crc_t crc_in,
                                                   sb_tx_pkg::sym_byte_t b);
    sb_tx_pkg::crc_t c;
    logic            fb;
    c = crc_in;
    for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ b[i];                           // Data bit against CRC LSB
        c  = c >> 1;
        if (fb) begin
            c = c ^ sb_tx_pkg::CRC_POLY_REFL;
        end
    end
    return c;
endfunction

// CRC over a whole body, zero seed
function automatic sb_tx_pkg::crc_t model_crc(model_byte_q_t body);
    sb_tx_pkg::crc_t c;
    c = '0;
    foreach (body[i]) begin
        c = model_crc_byte(c, body[i]);
    end
    return c;
endfunction

// Expected line bytes for a request, empty for a rejected kind
function automatic model_byte_q_t model_frame(sb_tx_pkg::txn_kind_t kind,
                                              sb_tx_pkg::rd_data_t data);
    model_byte_q_t   frame;
    model_byte_q_t   body;
    sb_tx_pkg::crc_t c;
    frame = {};
    body  = {};
    if (kind == sb_tx_pkg::KIND_LSE) begin
        frame.push_back(sb_tx_pkg::DLE_SYM);
        frame.push_back(sb_tx_pkg::LSE_SYM);
        frame.push_back(sb_tx_pkg::CLSE_SYM);       // Training pair has no CRC
    end else if ((kind == sb_tx_pkg::KIND_RD_CMD) || (kind == sb_tx_pkg::KIND_RD_RSP)) begin
        body.push_back((kind == sb_tx_pkg::KIND_RD_RSP) ? sb_tx_pkg::STX_RSP_SYM
                                                        : sb_tx_pkg::STX_CMD_SYM);
        body.push_back(sb_tx_pkg::RD_ADDR);
        body.push_back(sb_tx_pkg::RD_LEN);
        if (kind == sb_tx_pkg::KIND_RD_RSP) begin
            for (int i = 0; i < sb_tx_pkg::RD_DATA_BYTES; i++) begin
                body.push_back(data[8*i +: 8]);     // Byte 0 first
            end
        end
        c = model_crc(body);
        frame.push_back(sb_tx_pkg::DLE_SYM);
        foreach (body[i]) begin
            frame.push_back(body[i]);
        end
        frame.push_back(c[7:0]);                    // Low byte first
        frame.push_back(c[15:8]);
        frame.push_back(sb_tx_pkg::DLE_SYM);
        frame.push_back(sb_tx_pkg::ETX_SYM);
    end
    return frame;
endfunction

`endif

// ==== sb_tx_tb.sv ====
`timescale 1ns/10ps

module sb_tx_tb;
    import sb_tx_pkg::*;

    `include "sb_tx_tb_model.svh"

    localparam int NUM_ROWS       = 10;
    localparam int ROW_CYCLES     = MODEL_MAX_FRAME_SYMS * SYM_BITS +
                                    2 * DISCONNECT_MIN_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = 16 + DISCONNECT_MIN_CYCLES + NUM_ROWS * ROW_CYCLES + 200;

    logic        sb_clk;
    logic        rst;
    logic        req;
    txn_kind_t   trans_sel;
    rd_data_t    rd_data;
    logic        disconnect_sbtx;
    logic        ack;
    logic        sbtx;
    link_state_t link_state;
    logic        disconnected;

    // Stimulus table, one transaction per row
    txn_kind_t   row_kind    [NUM_ROWS];
    rd_data_t    row_data    [NUM_ROWS];
    logic        row_disc    [NUM_ROWS];   // Disconnect before the request
    int          row_exp_len [NUM_ROWS];   // Symbols expected on the line

    int          error_cnt = 0;
    int          cycle_cnt = 0;

    sb_tx_top UUT (
        .sb_clk          (sb_clk),
        .rst             (rst),
        .req             (req),
        .trans_sel       (trans_sel),
        .rd_data         (rd_data),
        .disconnect_sbtx (disconnect_sbtx),
        .ack             (ack),
        .sbtx            (sbtx),
        .link_state      (link_state),
        .disconnected    (disconnected)
    );

    initial begin
        sb_clk = 1'b0;
        forever #50 sb_clk = ~sb_clk;   // 100 ns period
    end

    // Run length guard
    always @(posedge sb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("TB FAILED");
            $fatal(1, "Run aborted on timeout");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic add_row(input int idx, input txn_kind_t kind, input logic rand_data,
                           input logic disc, input int exp_len);
        row_kind[idx]    = kind;
        row_data[idx]    = rand_data ? rd_data_t'($urandom) : '0;   // Random response data
        row_disc[idx]    = disc;
        row_exp_len[idx] = exp_len;
    endtask

    // Counts quiet cycles until the link reports idle
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (1) begin
            @(negedge sb_clk);
            quiet++;
            if (link_state == LINK_IDLE) break;
            check_val("sbtx while disconnected", 32'(sbtx), 32'(0));
            check_val("disconnected", 32'(disconnected), 32'(1));
            check_val("ack while disconnected", 32'(ack), 32'(0));
        end
        check_val("quiet time long enough", 32'(quiet >= DISCONNECT_MIN_CYCLES), 32'(1));
        check_val("sbtx idle level", 32'(sbtx), 32'(1));
        check_val("disconnected after quiet", 32'(disconnected), 32'(0));
    endtask

    task automatic force_disconnect();
        @(posedge sb_clk);
        disconnect_sbtx <= 1'b1;
        @(posedge sb_clk);                    // Sequencer leaves IDLE here
        repeat (4) begin
            @(negedge sb_clk);
            check_val("sbtx in disconnect", 32'(sbtx), 32'(0));
            check_val("disconnected", 32'(disconnected), 32'(1));
            check_val("link_state", 32'(link_state), 32'(LINK_DISCONNECTED));
        end
        @(posedge sb_clk);
        disconnect_sbtx <= 1'b0;
        wait_quiet();
    endtask

    // Request, deserialize the line until ack, compare, close handshake
    task automatic run_row(input int r);
        model_byte_q_t exp_q;
        model_byte_q_t got_q;
        sym_byte_t     b;
        logic          got_ack;
        exp_q = model_frame(row_kind[r], row_data[r]);
        got_q = {};
        got_ack = 1'b0;
        check_val("model frame length", 32'(exp_q.size()), 32'(row_exp_len[r]));
        @(posedge sb_clk);
        req       <= 1'b1;
        trans_sel <= row_kind[r];
        rd_data   <= row_data[r];
        while (!got_ack) begin
            @(negedge sb_clk);
            if (ack) begin
                got_ack = 1'b1;
                check_val("link_state with ack", 32'(link_state), 32'(LINK_BUSY));
            end else if (!sbtx) begin          // Start bit
                for (int i = 0; i < 8; i++) begin
                    @(negedge sb_clk);
                    check_val("ack during frame", 32'(ack), 32'(0));
                    check_val("link_state during frame", 32'(link_state), 32'(LINK_BUSY));
                    b[i] = sbtx;               // LSB first
                end
                @(negedge sb_clk);
                check_val("sbtx stop bit", 32'(sbtx), 32'(1));
                got_q.push_back(b);
            end else if (got_q.size() != 0) begin
                check_val("start bit after stop bit", 32'(sbtx), 32'(0));  // Back to back
            end
        end
        check_val("frame length", 32'(got_q.size()), 32'(exp_q.size()));
        foreach (got_q[i]) begin
            check_val($sformatf("frame byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
        end
        @(posedge sb_clk);
        req <= 1'b0;
        @(negedge sb_clk);
        check_val("ack held until req seen low", 32'(ack), 32'(1));
        @(negedge sb_clk);
        check_val("ack after req low", 32'(ack), 32'(0));
        check_val("link_state back to idle", 32'(link_state), 32'(LINK_IDLE));
        check_val("sbtx idle after frame", 32'(sbtx), 32'(1));
    endtask

    initial begin
        rst             = 1'b0;
        req             = 1'b0;
        trans_sel       = '0;
        rd_data         = '0;
        disconnect_sbtx = 1'b0;
        void'($urandom(74));                 // Fixed seed for the random rows

        add_row(0, KIND_RD_CMD, 1'b0, 1'b0, 8);
        add_row(1, KIND_RD_RSP, 1'b1, 1'b0, 11);
        add_row(2, KIND_LSE,    1'b0, 1'b0, 3);
        add_row(3, 3'd0,        1'b0, 1'b0, 0);   // Invalid kind
        add_row(4, KIND_RD_RSP, 1'b1, 1'b0, 11);
        add_row(5, KIND_RD_CMD, 1'b1, 1'b1, 8);
        add_row(6, 3'd7,        1'b0, 1'b0, 0);
        add_row(7, KIND_LSE,    1'b0, 1'b1, 3);
        add_row(8, KIND_RD_RSP, 1'b1, 1'b0, 11);
        add_row(9, KIND_RD_RSP, 1'b1, 1'b0, 11);

        for (int i = 0; i < 16; i++) begin
            @(negedge sb_clk);
            check_val("sbtx in reset", 32'(sbtx), 32'(0));
            check_val("disconnected in reset", 32'(disconnected), 32'(1));
            check_val("link_state in reset", 32'(link_state), 32'(LINK_DISCONNECTED));
            check_val("ack in reset", 32'(ack), 32'(0));
        end
        @(posedge sb_clk);
        rst <= 1'b1;
        wait_quiet();                         // First IDLE after reset

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_disc[r]) begin
                force_disconnect();
            end
            run_row(r);
        end

        repeat (5) @(negedge sb_clk);
        if (error_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Errors were found");
        end
    end

endmodule

// ==== sb_tx_top.f ====
+incdir+.
sb_tx_pkg.sv
sb_symbol_serializer.sv
sb_crc16.sv
sb_txn_sequencer.sv
sb_tx_top.sv
sb_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sideband transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sb_tx_top.f \
    --top-module sb_tx_tb \
    --Mdir obj_dir \
    -o sb_tx_sim

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/sb_tx_sim
